// ==== rtl/llc_pkg.sv ====
/* llc shared sizes and types */
`default_nettype none

package llc_pkg;

    localparam int NUM_WAYS       = 4;
    localparam int WAY_BITS       = 2;
    localparam int SET_BITS       = 6;
    localparam int NUM_SETS       = 64;
    localparam int BANKS_PER_WAY  = 2;
    localparam int BANK_SET_BITS  = 5;
    localparam int TAG_BITS       = 10;
    localparam int LINE_BITS      = 32;
    localparam int SRAMS_PER_LINE = 2;
    localparam int SRAM_BITS      = LINE_BITS / SRAMS_PER_LINE;
    localparam int ADR_BITS       = 16;
    localparam int CNT_BITS       = 9;

    // mixed word: {dirty, state, tag}, padded up to the sram width
    localparam int MIXED_BITS      = 13;
    localparam int MIXED_TAG_LO    = 0;
    localparam int MIXED_STATE_LO  = TAG_BITS;
    localparam int MIXED_DIRTY_POS = TAG_BITS + 2;

    typedef enum logic [1:0] {
        ST_INVALID  = 2'd0,
        ST_VALID    = 2'd1,
        ST_MODIFIED = 2'd2
    } llc_state_e;

    typedef enum logic [1:0] {
        OP_IDLE, OP_READ, OP_WRITE, OP_FLUSH
    } llc_op_e;

    typedef enum logic [2:0] {
        LK_IDLE, LK_READ, LK_CMP, LK_WRITE, LK_ACK
    } lookup_fsm_e;

    typedef enum logic [2:0] {
        FL_IDLE, FL_READ, FL_COUNT, FL_CLEAR, FL_ACK
    } flush_fsm_e;

endpackage

`default_nettype wire

// ==== rtl/llc_sram.sv ====
/* behavioural single-port sram */
`default_nettype none

module llc_sram
    import llc_pkg::*;
(
    input  logic                     clk,
    input  logic                     req_i,
    input  logic                     we_i,
    input  logic [BANK_SET_BITS-1:0] addr_i,
    input  logic [SRAM_BITS-1:0]     wdata_i,
    input  logic [SRAM_BITS-1:0]     be_i,
    output logic [SRAM_BITS-1:0]     rdata_o
);

    logic [SRAM_BITS-1:0] mem [2**BANK_SET_BITS];

    // read returns the old word when a write hits the same address
    always_ff @(posedge clk) begin
        if (req_i) begin
            if (we_i) begin
                mem[addr_i] <= (mem[addr_i] & ~be_i) | (wdata_i & be_i);
            end
            rdata_o <= mem[addr_i];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/llc_localmem.sv ====
/* llc way-banked local memory */
`default_nettype none

module llc_localmem
    import llc_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  llc_op_e              op_i,
    input  logic [SET_BITS-1:0]  set_i,
    input  logic [WAY_BITS-1:0]  way_i,
    input  logic [TAG_BITS-1:0]  tag_i,
    input  logic [LINE_BITS-1:0] line_i,
    input  llc_state_e           state_i,
    input  logic                 dirty_i,
    input  logic                 wr_evict_i,
    input  logic [WAY_BITS-1:0]  evict_way_i,
    output logic [TAG_BITS-1:0]  rd_tag_o [NUM_WAYS],
    output llc_state_e           rd_state_o [NUM_WAYS],
    output logic                 rd_dirty_o [NUM_WAYS],
    output logic [LINE_BITS-1:0] rd_line_o [NUM_WAYS],
    output logic [WAY_BITS-1:0]  rd_evict_way_o
);

    logic                 req;
    logic                 wr;
    logic                 fl;
    logic                 bank_q;
    logic [SRAM_BITS-1:0] mixed_wdata;
    logic [SRAM_BITS-1:0] mixed_be;
    logic [SRAM_BITS-1:0] rd_mixed [NUM_WAYS][BANKS_PER_WAY];
    logic [LINE_BITS-1:0] rd_line [NUM_WAYS][BANKS_PER_WAY];
    logic [WAY_BITS-1:0]  evict_arr [NUM_SETS];

    assign req = (op_i != OP_IDLE);
    assign wr  = (op_i == OP_WRITE);
    assign fl  = (op_i == OP_FLUSH);

    always_comb begin
        mixed_wdata = '0;
        mixed_wdata[MIXED_TAG_LO +: TAG_BITS] = tag_i;
        mixed_wdata[MIXED_STATE_LO +: 2] = state_i;
        mixed_wdata[MIXED_DIRTY_POS] = dirty_i;
        mixed_be = '0;
        if (wr) begin
            mixed_be[MIXED_BITS-1:0] = '1;
        end
        // flush only touches state and dirty
        if (fl) begin
            mixed_be[MIXED_STATE_LO +: 2] = '1;
            mixed_be[MIXED_DIRTY_POS] = 1'b1;
        end
    end

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        for (genvar b = 0; b < BANKS_PER_WAY; b++) begin : g_bank
            logic bank_hit;
            logic way_hit;

            assign bank_hit = (set_i[SET_BITS-1] == b);
            assign way_hit  = (way_i == w);

            llc_sram u_mixed (
                .clk     (clk),
                .req_i   (req),
                .we_i    (bank_hit & (fl | (wr & way_hit))),
                .addr_i  (set_i[BANK_SET_BITS-1:0]),
                .wdata_i (mixed_wdata),
                .be_i    (mixed_be),
                .rdata_o (rd_mixed[w][b])
            );

            for (genvar k = 0; k < SRAMS_PER_LINE; k++) begin : g_line
                llc_sram u_line (
                    .clk     (clk),
                    .req_i   (req),
                    .we_i    (bank_hit & wr & way_hit),
                    .addr_i  (set_i[BANK_SET_BITS-1:0]),
                    .wdata_i (line_i[k*SRAM_BITS +: SRAM_BITS]),
                    .be_i    ({SRAM_BITS{1'b1}}),
                    .rdata_o (rd_line[w][b][k*SRAM_BITS +: SRAM_BITS])
                );
            end
        end
    end

    // outputs come from the bank of the last command
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            rd_tag_o[w]   = rd_mixed[w][bank_q][MIXED_TAG_LO +: TAG_BITS];
            rd_state_o[w] = llc_state_e'(rd_mixed[w][bank_q][MIXED_STATE_LO +: 2]);
            rd_dirty_o[w] = rd_mixed[w][bank_q][MIXED_DIRTY_POS];
            rd_line_o[w]  = rd_line[w][bank_q];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bank_q <= 1'b0;
            rd_evict_way_o <= '0;
            for (int s = 0; s < NUM_SETS; s++) begin
                evict_arr[s] <= '0;
            end
        end else begin
            if (wr_evict_i) begin
                evict_arr[set_i] <= evict_way_i;
            end
            if (req) begin
                bank_q <= set_i[SET_BITS-1];
                rd_evict_way_o <= evict_arr[set_i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/llc_mem_arbiter.sv ====
/* round-robin memory arbiter */
`default_nettype none

module llc_mem_arbiter
    import llc_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 lk_req_i,
    input  llc_op_e              lk_op_i,
    input  logic [SET_BITS-1:0]  lk_set_i,
    input  logic [WAY_BITS-1:0]  lk_way_i,
    input  logic [TAG_BITS-1:0]  lk_tag_i,
    input  logic [LINE_BITS-1:0] lk_line_i,
    input  llc_state_e           lk_state_i,
    input  logic                 lk_dirty_i,
    input  logic                 lk_wr_evict_i,
    input  logic [WAY_BITS-1:0]  lk_evict_way_i,
    output logic                 lk_gnt_o,
    input  logic                 fl_req_i,
    input  llc_op_e              fl_op_i,
    input  logic [SET_BITS-1:0]  fl_set_i,
    input  llc_state_e           fl_state_i,
    input  logic                 fl_dirty_i,
    output logic                 fl_gnt_o,
    output llc_op_e              mem_op_o,
    output logic [SET_BITS-1:0]  mem_set_o,
    output logic [WAY_BITS-1:0]  mem_way_o,
    output logic [TAG_BITS-1:0]  mem_tag_o,
    output logic [LINE_BITS-1:0] mem_line_o,
    output llc_state_e           mem_state_o,
    output logic                 mem_dirty_o,
    output logic                 mem_wr_evict_o,
    output logic [WAY_BITS-1:0]  mem_evict_way_o
);

    // set when the lookup port won the last grant
    logic last_lk_q;

    assign lk_gnt_o = lk_req_i & (~fl_req_i | ~last_lk_q);
    assign fl_gnt_o = fl_req_i & ~lk_gnt_o;

    always_comb begin
        mem_op_o        = OP_IDLE;
        mem_set_o       = fl_set_i;
        mem_way_o       = '0;
        mem_tag_o       = '0;
        mem_line_o      = '0;
        mem_state_o     = fl_state_i;
        mem_dirty_o     = fl_dirty_i;
        mem_wr_evict_o  = 1'b0;
        mem_evict_way_o = '0;
        if (lk_gnt_o) begin
            mem_op_o        = lk_op_i;
            mem_set_o       = lk_set_i;
            mem_way_o       = lk_way_i;
            mem_tag_o       = lk_tag_i;
            mem_line_o      = lk_line_i;
            mem_state_o     = lk_state_i;
            mem_dirty_o     = lk_dirty_i;
            mem_wr_evict_o  = lk_wr_evict_i;
            mem_evict_way_o = lk_evict_way_i;
        end else if (fl_gnt_o) begin
            mem_op_o = fl_op_i;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            last_lk_q <= 1'b0;
        end else if (lk_gnt_o | fl_gnt_o) begin
            last_lk_q <= lk_gnt_o;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/llc_lookup.sv ====
/* llc lookup engine */
`default_nettype none

module llc_lookup
    import llc_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 lk_cyc_i,
    input  logic                 lk_stb_i,
    input  logic                 lk_we_i,
    input  logic [ADR_BITS-1:0]  lk_adr_i,
    input  logic [LINE_BITS-1:0] lk_dat_i,
    output logic [LINE_BITS-1:0] lk_dat_o,
    output logic                 lk_ack_o,
    output logic                 lk_hit_o,
    output logic [WAY_BITS-1:0]  lk_way_o,
    input  logic                 init_done_i,
    output logic                 mem_req_o,
    input  logic                 mem_gnt_i,
    output llc_op_e              mem_op_o,
    output logic [SET_BITS-1:0]  mem_set_o,
    output logic [WAY_BITS-1:0]  mem_way_o,
    output logic [TAG_BITS-1:0]  mem_tag_o,
    output logic [LINE_BITS-1:0] mem_line_o,
    output llc_state_e           mem_state_o,
    output logic                 mem_dirty_o,
    output logic                 mem_wr_evict_o,
    output logic [WAY_BITS-1:0]  mem_evict_way_o,
    input  logic [TAG_BITS-1:0]  rd_tag_i [NUM_WAYS],
    input  llc_state_e           rd_state_i [NUM_WAYS],
    input  logic [LINE_BITS-1:0] rd_line_i [NUM_WAYS],
    input  logic [WAY_BITS-1:0]  rd_evict_way_i
);

    lookup_fsm_e          state_q;
    logic                 hit;
    logic [WAY_BITS-1:0]  hit_way;
    logic                 hit_q;
    logic [WAY_BITS-1:0]  way_q;
    logic [LINE_BITS-1:0] dat_q;

    // wishbone inputs are held until ack, so the address is used directly
    assign mem_set_o       = lk_adr_i[SET_BITS-1:0];
    assign mem_tag_o       = lk_adr_i[ADR_BITS-1 -: TAG_BITS];
    assign mem_line_o      = lk_dat_i;
    assign mem_way_o       = way_q;
    assign mem_state_o     = ST_MODIFIED;
    assign mem_dirty_o     = 1'b1;
    assign mem_req_o       = (state_q == LK_READ) || (state_q == LK_WRITE);
    assign mem_op_o        = (state_q == LK_WRITE) ? OP_WRITE :
                             (state_q == LK_READ) ? OP_READ : OP_IDLE;
    // a miss allocation moves the set's victim pointer on
    assign mem_wr_evict_o  = (state_q == LK_WRITE) && !hit_q;
    assign mem_evict_way_o = way_q + 1'b1;

    assign lk_ack_o = (state_q == LK_ACK);
    assign lk_hit_o = hit_q;
    assign lk_way_o = way_q;
    assign lk_dat_o = dat_q;

    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (rd_state_i[w] != ST_INVALID && rd_tag_i[w] == mem_tag_o) begin
                hit = 1'b1;
                hit_way = WAY_BITS'(w);
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= LK_IDLE;
            hit_q <= 1'b0;
            way_q <= '0;
            dat_q <= '0;
        end else begin
            case (state_q)
                LK_IDLE: if (lk_cyc_i && lk_stb_i && init_done_i) state_q <= LK_READ;
                LK_READ: if (mem_gnt_i) state_q <= LK_CMP;
                LK_CMP: begin
                    hit_q <= hit;
                    way_q <= hit ? hit_way : rd_evict_way_i;
                    dat_q <= (hit && !lk_we_i) ? rd_line_i[hit_way] : '0;
                    state_q <= lk_we_i ? LK_WRITE : LK_ACK;
                end
                LK_WRITE: if (mem_gnt_i) state_q <= LK_ACK;
                default: state_q <= LK_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/llc_flush.sv ====
/* llc flush engine */
`default_nettype none

module llc_flush
    import llc_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fl_cyc_i,
    input  logic                 fl_stb_i,
    input  logic                 fl_we_i,
    output logic [LINE_BITS-1:0] fl_dat_o,
    output logic                 fl_ack_o,
    output logic                 init_done_o,
    output logic                 mem_req_o,
    input  logic                 mem_gnt_i,
    output llc_op_e              mem_op_o,
    output logic [SET_BITS-1:0]  mem_set_o,
    output llc_state_e           mem_state_o,
    output logic                 mem_dirty_o,
    input  llc_state_e           rd_state_i [NUM_WAYS],
    input  logic                 rd_dirty_i [NUM_WAYS]
);

    flush_fsm_e          state_q;
    logic [SET_BITS-1:0] set_q;
    logic [CNT_BITS-1:0] cnt_q;
    logic [2:0]          set_dirty;

    assign mem_req_o   = (state_q == FL_READ) || (state_q == FL_CLEAR);
    assign mem_op_o    = (state_q == FL_CLEAR) ? OP_FLUSH :
                         (state_q == FL_READ) ? OP_READ : OP_IDLE;
    assign mem_set_o   = set_q;
    assign mem_state_o = ST_INVALID;
    assign mem_dirty_o = 1'b0;
    assign fl_ack_o    = (state_q == FL_ACK);
    assign fl_dat_o    = {{(LINE_BITS-CNT_BITS){1'b0}}, cnt_q};

    always_comb begin
        set_dirty = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (rd_state_i[w] != ST_INVALID && rd_dirty_i[w]) begin
                set_dirty = set_dirty + 3'd1;
            end
        end
    end

    // reset starts a walk on its own, which clears the whole memory
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= FL_READ;
            set_q <= '0;
            cnt_q <= '0;
            init_done_o <= 1'b0;
        end else begin
            case (state_q)
                FL_IDLE: begin
                    if (fl_cyc_i && fl_stb_i) begin
                        if (fl_we_i) begin
                            cnt_q <= '0;
                        end
                        state_q <= fl_we_i ? FL_READ : FL_ACK;
                    end
                end
                FL_READ: if (mem_gnt_i) state_q <= FL_COUNT;
                FL_COUNT: begin
                    cnt_q <= cnt_q + CNT_BITS'(set_dirty);
                    state_q <= FL_CLEAR;
                end
                FL_CLEAR: begin
                    if (mem_gnt_i) begin
                        set_q <= set_q + 1'b1;
                        if (set_q != SET_BITS'(NUM_SETS - 1)) begin
                            state_q <= FL_READ;
                        end else if (!init_done_o) begin
                            // power-up contents are not a real count
                            init_done_o <= 1'b1;
                            cnt_q <= '0;
                            state_q <= FL_IDLE;
                        end else begin
                            state_q <= FL_ACK;
                        end
                    end
                end
                default: state_q <= FL_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/llc_top.sv ====
/* llc tag and data store top */
`default_nettype none

module llc_top
    import llc_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 lk_cyc_i,
    input  logic                 lk_stb_i,
    input  logic                 lk_we_i,
    input  logic [ADR_BITS-1:0]  lk_adr_i,
    input  logic [LINE_BITS-1:0] lk_dat_i,
    output logic [LINE_BITS-1:0] lk_dat_o,
    output logic                 lk_ack_o,
    output logic                 lk_hit_o,
    output logic [WAY_BITS-1:0]  lk_way_o,
    input  logic                 fl_cyc_i,
    input  logic                 fl_stb_i,
    input  logic                 fl_we_i,
    output logic [LINE_BITS-1:0] fl_dat_o,
    output logic                 fl_ack_o
);

    logic                 init_done;
    logic                 lk_req, lk_gnt, fl_req, fl_gnt;
    llc_op_e              lk_op, fl_op, mem_op;
    logic [SET_BITS-1:0]  lk_set, fl_set, mem_set;
    logic [WAY_BITS-1:0]  lk_way, mem_way;
    logic [TAG_BITS-1:0]  lk_tag, mem_tag;
    logic [LINE_BITS-1:0] lk_line, mem_line;
    llc_state_e           lk_state, fl_state, mem_state;
    logic                 lk_dirty, fl_dirty, mem_dirty;
    logic                 lk_wr_evict, mem_wr_evict;
    logic [WAY_BITS-1:0]  lk_evict_way, mem_evict_way, rd_evict_way;
    logic [TAG_BITS-1:0]  rd_tag [NUM_WAYS];
    llc_state_e           rd_state [NUM_WAYS];
    logic                 rd_dirty [NUM_WAYS];
    logic [LINE_BITS-1:0] rd_line [NUM_WAYS];

    llc_lookup u_lookup (
        .clk, .rst, .lk_cyc_i, .lk_stb_i, .lk_we_i, .lk_adr_i, .lk_dat_i,
        .lk_dat_o, .lk_ack_o, .lk_hit_o, .lk_way_o,
        .init_done_i     (init_done),
        .mem_req_o       (lk_req),
        .mem_gnt_i       (lk_gnt),
        .mem_op_o        (lk_op),
        .mem_set_o       (lk_set),
        .mem_way_o       (lk_way),
        .mem_tag_o       (lk_tag),
        .mem_line_o      (lk_line),
        .mem_state_o     (lk_state),
        .mem_dirty_o     (lk_dirty),
        .mem_wr_evict_o  (lk_wr_evict),
        .mem_evict_way_o (lk_evict_way),
        .rd_tag_i        (rd_tag),
        .rd_state_i      (rd_state),
        .rd_line_i       (rd_line),
        .rd_evict_way_i  (rd_evict_way)
    );

    llc_flush u_flush (
        .clk, .rst, .fl_cyc_i, .fl_stb_i, .fl_we_i, .fl_dat_o, .fl_ack_o,
        .init_done_o (init_done),
        .mem_req_o   (fl_req),
        .mem_gnt_i   (fl_gnt),
        .mem_op_o    (fl_op),
        .mem_set_o   (fl_set),
        .mem_state_o (fl_state),
        .mem_dirty_o (fl_dirty),
        .rd_state_i  (rd_state),
        .rd_dirty_i  (rd_dirty)
    );

    llc_mem_arbiter u_arb (
        .clk, .rst,
        .lk_req_i (lk_req), .lk_op_i (lk_op), .lk_set_i (lk_set), .lk_way_i (lk_way),
        .lk_tag_i (lk_tag), .lk_line_i (lk_line), .lk_state_i (lk_state),
        .lk_dirty_i (lk_dirty), .lk_wr_evict_i (lk_wr_evict),
        .lk_evict_way_i (lk_evict_way), .lk_gnt_o (lk_gnt),
        .fl_req_i (fl_req), .fl_op_i (fl_op), .fl_set_i (fl_set),
        .fl_state_i (fl_state), .fl_dirty_i (fl_dirty), .fl_gnt_o (fl_gnt),
        .mem_op_o (mem_op), .mem_set_o (mem_set), .mem_way_o (mem_way),
        .mem_tag_o (mem_tag), .mem_line_o (mem_line), .mem_state_o (mem_state),
        .mem_dirty_o (mem_dirty), .mem_wr_evict_o (mem_wr_evict),
        .mem_evict_way_o (mem_evict_way)
    );

    llc_localmem u_mem (
        .clk, .rst,
        .op_i (mem_op), .set_i (mem_set), .way_i (mem_way), .tag_i (mem_tag),
        .line_i (mem_line), .state_i (mem_state), .dirty_i (mem_dirty),
        .wr_evict_i (mem_wr_evict), .evict_way_i (mem_evict_way),
        .rd_tag_o (rd_tag), .rd_state_o (rd_state), .rd_dirty_o (rd_dirty),
        .rd_line_o (rd_line), .rd_evict_way_o (rd_evict_way)
    );

endmodule

`default_nettype wire

// ==== dv/llc_sva.sv ====
/* llc handshake assertions */
`default_nettype none

module llc_sva
    import llc_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    lk_cyc_i,
    input logic    lk_stb_i,
    input logic    lk_ack_i,
    input logic    fl_cyc_i,
    input logic    fl_stb_i,
    input logic    fl_ack_i,
    input logic    lk_gnt_i,
    input logic    fl_gnt_i,
    input llc_op_e mem_op_i
);

    // acks are one-cycle pulses inside an open bus cycle
    lk_ack_pulse: assert property (@(posedge clk) disable iff (!rst) lk_ack_i |=> !lk_ack_i)
        else $error("lookup ack held for more than one cycle");
    lk_ack_inside: assert property (@(posedge clk) disable iff (!rst)
        lk_ack_i |-> (lk_cyc_i && lk_stb_i))
        else $error("lookup ack outside cyc and stb");
    fl_ack_pulse: assert property (@(posedge clk) disable iff (!rst) fl_ack_i |=> !fl_ack_i)
        else $error("flush ack held for more than one cycle");
    fl_ack_inside: assert property (@(posedge clk) disable iff (!rst)
        fl_ack_i |-> (fl_cyc_i && fl_stb_i))
        else $error("flush ack outside cyc and stb");

    gnt_onehot: assert property (@(posedge clk) disable iff (!rst) !(lk_gnt_i && fl_gnt_i))
        else $error("both memory grants high");
    op_idle: assert property (@(posedge clk) disable iff (!rst)
        (!lk_gnt_i && !fl_gnt_i) |-> (mem_op_i == OP_IDLE))
        else $error("memory op issued without a grant");

endmodule

bind llc_top llc_sva u_sva (
    .clk      (clk),
    .rst      (rst),
    .lk_cyc_i (lk_cyc_i),
    .lk_stb_i (lk_stb_i),
    .lk_ack_i (lk_ack_o),
    .fl_cyc_i (fl_cyc_i),
    .fl_stb_i (fl_stb_i),
    .fl_ack_i (fl_ack_o),
    .lk_gnt_i (lk_gnt),
    .fl_gnt_i (fl_gnt),
    .mem_op_i (mem_op)
);

`default_nettype wire

// ==== dv/llc_tb.sv ====
/* llc testbench */
`default_nettype none

module llc_tb
    import llc_pkg::*;
();

    localparam logic [1:0]          PORT_LK   = 2'd0;
    localparam logic [1:0]          PORT_FL   = 2'd1;
    // lookup entry with a flush walk started in the same cycle
    localparam logic [1:0]          PORT_BOTH = 2'd2;
    localparam int                  TIMEOUT   = 1000;
    localparam logic [15:0]         LFSR_SEED = 16'd6;
    localparam logic [ADR_BITS-1:0] ADR_A     = {10'h155, 6'd33};
    localparam logic [ADR_BITS-1:0] ADR_B     = {10'h3c3, 6'd63};

    typedef struct packed {
        logic [1:0]           port;
        logic                 we;
        logic [ADR_BITS-1:0]  adr;
        logic [LINE_BITS-1:0] dat;
        logic [LINE_BITS-1:0] exp_dat;
        logic                 exp_hit;
        logic [WAY_BITS-1:0]  exp_way;
        logic [CNT_BITS-1:0]  exp_cnt;
    } entry_t;

    logic                 clk;
    logic                 rst;
    logic                 lk_cyc;
    logic                 lk_stb;
    logic                 lk_we;
    logic [ADR_BITS-1:0]  lk_adr;
    logic [LINE_BITS-1:0] lk_dat;
    logic [LINE_BITS-1:0] lk_rdat;
    logic                 lk_ack;
    logic                 lk_hit;
    logic [WAY_BITS-1:0]  lk_way;
    logic                 fl_cyc;
    logic                 fl_stb;
    logic                 fl_we;
    logic [LINE_BITS-1:0] fl_rdat;
    logic                 fl_ack;

    entry_t               tbl [$];
    logic [15:0]          lfsr;

    // reference model of the cache contents
    logic                 m_valid [NUM_SETS][NUM_WAYS];
    logic [TAG_BITS-1:0]  m_tag [NUM_SETS][NUM_WAYS];
    logic [LINE_BITS-1:0] m_line [NUM_SETS][NUM_WAYS];
    logic [WAY_BITS-1:0]  m_evict [NUM_SETS];
    logic [CNT_BITS-1:0]  m_last_cnt;

    llc_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .lk_cyc_i (lk_cyc),
        .lk_stb_i (lk_stb),
        .lk_we_i  (lk_we),
        .lk_adr_i (lk_adr),
        .lk_dat_i (lk_dat),
        .lk_dat_o (lk_rdat),
        .lk_ack_o (lk_ack),
        .lk_hit_o (lk_hit),
        .lk_way_o (lk_way),
        .fl_cyc_i (fl_cyc),
        .fl_stb_i (fl_stb),
        .fl_we_i  (fl_we),
        .fl_dat_o (fl_rdat),
        .fl_ack_o (fl_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // 16-bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], rand_bit()};
        end
        return v;
    endfunction

    function automatic void model_clear();
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w] = '0;
                m_line[s][w] = '0;
            end
            m_evict[s] = '0;
        end
        m_last_cnt = '0;
    endfunction

    // every stored line is dirty, so the walk counts all valid lines
    function automatic logic [CNT_BITS-1:0] model_flush();
        logic [CNT_BITS-1:0] cnt;
        cnt = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (m_valid[s][w]) begin
                    cnt = cnt + CNT_BITS'(1);
                end
                m_valid[s][w] = 1'b0;
            end
        end
        return cnt;
    endfunction

    function automatic void add_entry(logic [1:0] port, logic we, logic [ADR_BITS-1:0] adr,
                                      logic [LINE_BITS-1:0] dat);
        entry_t              e;
        logic [SET_BITS-1:0] set;
        logic [TAG_BITS-1:0] tag;
        logic [WAY_BITS-1:0] way;
        logic                hit;
        e = '0;
        e.port = port;
        e.we = we;
        e.adr = adr;
        e.dat = dat;
        set = adr[SET_BITS-1:0];
        tag = adr[ADR_BITS-1 -: TAG_BITS];
        if (port != PORT_FL) begin
            hit = 1'b0;
            way = m_evict[set];
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (m_valid[set][w] && m_tag[set][w] == tag) begin
                    hit = 1'b1;
                    way = WAY_BITS'(w);
                end
            end
            e.exp_hit = hit;
            e.exp_way = way;
            e.exp_dat = (hit && !we) ? m_line[set][way] : '0;
            if (we) begin
                m_valid[set][way] = 1'b1;
                m_tag[set][way] = tag;
                m_line[set][way] = dat;
                if (!hit) begin
                    m_evict[set] = way + 2'd1;
                end
            end
        end
        // a combined lookup finishes long before the walk reaches a high set
        if (port != PORT_LK) begin
            if (port == PORT_BOTH || we) begin
                m_last_cnt = model_flush();
            end
            e.exp_cnt = m_last_cnt;
        end
        tbl.push_back(e);
    endfunction

    function automatic void build_table();
        logic [ADR_BITS-1:0]  adr;
        logic [LINE_BITS-1:0] dat;
        for (int i = 0; i < 6; i++) begin
            add_entry(PORT_LK, 1'b0, {TAG_BITS'(i * 37 + 3), SET_BITS'(i * 11)}, '0);
        end
        add_entry(PORT_LK, 1'b1, ADR_A, 32'ha5a5_0001);
        add_entry(PORT_LK, 1'b0, ADR_A, '0);
        // random stores stay in the lower bank, each one read back
        for (int i = 0; i < 8; i++) begin
            adr = ADR_BITS'(rand_bits(ADR_BITS));
            adr[SET_BITS-1] = 1'b0;
            dat = rand_bits(LINE_BITS);
            add_entry(PORT_LK, 1'b1, adr, dat);
            add_entry(PORT_LK, 1'b0, adr, '0);
        end
        // five tags into set 45 wrap the victim pointer
        for (int i = 0; i < 5; i++) begin
            add_entry(PORT_LK, 1'b1, {TAG_BITS'(16 + i), 6'd45}, 32'h3000_0000 + 32'(i));
        end
        add_entry(PORT_LK, 1'b0, {10'd16, 6'd45}, '0);
        add_entry(PORT_LK, 1'b0, {10'd20, 6'd45}, '0);
        add_entry(PORT_LK, 1'b1, {10'd17, 6'd45}, 32'hbeef_0017);
        add_entry(PORT_LK, 1'b0, {10'd17, 6'd45}, '0);
        add_entry(PORT_FL, 1'b1, '0, '0);
        add_entry(PORT_FL, 1'b0, '0, '0);
        add_entry(PORT_LK, 1'b0, ADR_A, '0);
        add_entry(PORT_LK, 1'b0, {10'd20, 6'd45}, '0);
        add_entry(PORT_FL, 1'b1, '0, '0);
        add_entry(PORT_FL, 1'b0, '0, '0);
        add_entry(PORT_LK, 1'b1, ADR_B, 32'h0bb0_63ff);
        add_entry(PORT_LK, 1'b1, ADR_A, 32'h0aa0_3321);
        add_entry(PORT_BOTH, 1'b0, ADR_B, '0);
        add_entry(PORT_FL, 1'b0, '0, '0);
        add_entry(PORT_LK, 1'b0, ADR_B, '0);
    endfunction

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp)
            else report_fail($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    task automatic run_entry(input entry_t e);
        logic lk_busy;
        logic fl_busy;
        logic lk_seen;
        logic fl_seen;
        int   cycles;
        lk_busy = (e.port != PORT_FL);
        fl_busy = (e.port != PORT_LK);
        @(posedge clk);
        #1;
        if (lk_busy) begin
            lk_cyc = 1'b1;
            lk_stb = 1'b1;
            lk_we = e.we;
            lk_adr = e.adr;
            lk_dat = e.dat;
        end
        if (fl_busy) begin
            fl_cyc = 1'b1;
            fl_stb = 1'b1;
            fl_we = (e.port == PORT_BOTH) || e.we;
        end
        cycles = 0;
        while (lk_busy || fl_busy) begin
            @(negedge clk);
            cycles++;
            lk_seen = lk_busy && lk_ack;
            fl_seen = fl_busy && fl_ack;
            if (lk_seen) begin
                check_val("lk_dat_o", lk_rdat, e.exp_dat);
                check_val("lk_hit_o", 32'(lk_hit), 32'(e.exp_hit));
                check_val("lk_way_o", 32'(lk_way), 32'(e.exp_way));
                lk_busy = 1'b0;
            end
            if (fl_seen) begin
                check_val("fl_dat_o", fl_rdat, 32'(e.exp_cnt));
                fl_busy = 1'b0;
            end
            assert (cycles < TIMEOUT)
                else report_fail($sformatf("no ack within %0d cycles for address %h",
                                           TIMEOUT, e.adr));
            // the master holds the bus through the ack cycle
            @(posedge clk);
            #1;
            if (lk_seen) begin
                lk_cyc = 1'b0;
                lk_stb = 1'b0;
                lk_we = 1'b0;
            end
            if (fl_seen) begin
                fl_cyc = 1'b0;
                fl_stb = 1'b0;
                fl_we = 1'b0;
            end
        end
    endtask

    initial begin
        rst = 1'b0;
        lk_cyc = 1'b0;
        lk_stb = 1'b0;
        lk_we = 1'b0;
        lk_adr = '0;
        lk_dat = '0;
        fl_cyc = 1'b0;
        fl_stb = 1'b0;
        fl_we = 1'b0;
        lfsr = LFSR_SEED;
        model_clear();
        build_table();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b1;
        foreach (tbl[i]) begin
            run_entry(tbl[i]);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/llc_pkg.sv
rtl/llc_sram.sv
rtl/llc_localmem.sv
rtl/llc_mem_arbiter.sv
rtl/llc_lookup.sv
rtl/llc_flush.sv
rtl/llc_top.sv
dv/llc_sva.sv
dv/llc_tb.sv

// ==== Makefile ====
# Verilator build and run for the llc testbench

VERILATOR ?= verilator
TOP       ?= llc_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
